// ==== verilog/hist_pkg.sv ====
////////////////////
// histogram readout shared definitions.
// channel count, burst structure and word types.
////////////////////

package hist_pkg;

    ////////////////////
    // readout structure

    localparam int NUM_CHN        = 4;  // histogram channels behind one mux.
    localparam int BURSTS_PER_CHN = 4;  // bursts per channel readout, power of two.

    ////////////////////
    // data words

    localparam int HIST_W = 32;         // bin count width.

    typedef logic [HIST_W-1:0] hist_word_t;  // one bin count.
    typedef logic [1:0]        chn_idx_t;    // channel number.

endpackage

// ==== verilog/hist_channel.sv ====
////////////////////
// histogram channel.
// counts pixels into bins, drains at frame end, reads out in bursts with clear.
////////////////////
`timescale 1ns/100ps

module hist_channel #(
    parameter int PIX_BITS = 8
) (
    input  logic                mclk,
    input  logic                rst_n,
    input  logic                pix_valid,
    input  logic [PIX_BITS-1:0] pix,
    input  logic                frame_end,
    input  logic                grant,
    output logic                rq,
    output logic                dav,
    output hist_pkg::hist_word_t dout
);

    import hist_pkg::*;

    localparam int NUM_BINS   = 1 << PIX_BITS;
    localparam int BURST_BITS = $clog2(BURSTS_PER_CHN);
    localparam int WORD_BITS  = PIX_BITS - BURST_BITS;  // bins per burst, log2.

    typedef enum logic [2:0] {
        ST_CLR,    // post-reset sweep.
        ST_ACC,    // counting pixels.
        ST_DRN0,   // rmw pipeline drain.
        ST_DRN1,
        ST_REQ,    // waiting for a grant.
        ST_BURST   // reading one burst.
    } state_t;

    state_t                st;
    logic [PIX_BITS-1:0]   bin_cnt;     // sweep / readout address.
    hist_word_t            mem [NUM_BINS];
    hist_word_t            rd_q;        // registered read data.
    logic [PIX_BITS-1:0]   mem_raddr;
    logic                  mem_we;
    logic [PIX_BITS-1:0]   mem_waddr;
    hist_word_t            mem_wdata;
    logic                  rd_burst;    // readout read this cycle.
    logic                  word_last;
    logic                  burst_last;
    logic                  s1_vld;      // pixel read in flight.
    logic [PIX_BITS-1:0]   s1_bin;
    logic                  fwd_vld;     // last accumulate write.
    logic [PIX_BITS-1:0]   fwd_bin;
    hist_word_t            fwd_val;
    hist_word_t            acc_base;
    hist_word_t            acc_sum;

    ////////////////////
    // address and write port select

    assign rd_burst   = ((st == ST_REQ) && grant) || (st == ST_BURST);
    assign word_last  = (bin_cnt[WORD_BITS-1:0] == {WORD_BITS{1'b1}});
    assign burst_last = (bin_cnt[PIX_BITS-1 -: BURST_BITS] == BURST_BITS'(BURSTS_PER_CHN - 1));
    assign mem_raddr  = rd_burst ? bin_cnt : pix;  // pixel bin while counting.

    assign acc_base = (fwd_vld && (fwd_bin == s1_bin)) ? fwd_val : rd_q;  // back-to-back bin.
    assign acc_sum  = acc_base + HIST_W'(1);

    always_comb begin
        mem_we    = 1'b0;
        mem_waddr = bin_cnt;
        mem_wdata = '0;
        if ((st == ST_CLR) || rd_burst) begin
            mem_we = 1'b1;                 // zero behind sweep or read.
        end else if (s1_vld) begin
            mem_we    = 1'b1;
            mem_waddr = s1_bin;
            mem_wdata = acc_sum;
        end
    end

    ////////////////////
    // bin memory, read before write

    always_ff @(posedge mclk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
        rd_q <= mem[mem_raddr];            // one cycle latency.
    end

    assign dout = rd_q;

    ////////////////////
    // rmw pipeline

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld  <= 1'b0;
            fwd_vld <= 1'b0;
        end else begin
            s1_vld  <= pix_valid && (st == ST_ACC);  // pixels ignored otherwise.
            fwd_vld <= s1_vld;
        end
    end

    always_ff @(posedge mclk) begin
        s1_bin  <= pix;
        fwd_bin <= s1_bin;
        fwd_val <= acc_sum;
    end

    ////////////////////
    // control fsm

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            st      <= ST_CLR;
            bin_cnt <= '0;
            rq      <= 1'b0;
            dav     <= 1'b0;
        end else begin
            dav <= rd_burst;               // data follows the read by one cycle.
            case (st)
                ST_CLR: begin
                    bin_cnt <= bin_cnt + 1'b1;
                    if (bin_cnt == {PIX_BITS{1'b1}}) begin
                        st <= ST_ACC;      // counter wraps to zero.
                    end
                end
                ST_ACC: begin
                    if (frame_end) begin
                        st <= ST_DRN0;
                    end
                end
                ST_DRN0: st <= ST_DRN1;
                ST_DRN1: begin
                    st <= ST_REQ;
                    rq <= 1'b1;
                end
                ST_REQ: begin
                    if (grant) begin
                        st      <= ST_BURST;
                        bin_cnt <= bin_cnt + 1'b1;
                        if (burst_last) begin
                            rq <= 1'b0;    // last burst launched.
                        end
                    end
                end
                ST_BURST: begin
                    bin_cnt <= bin_cnt + 1'b1;
                    if (word_last) begin
                        st <= burst_last ? ST_ACC : ST_REQ;
                    end
                end
                default: st <= ST_CLR;
            endcase
        end
    end

    ////////////////////
    // checks

    a_dav_in_burst: assert property (@(posedge mclk) disable iff (!rst_n)
        dav |-> (st == ST_BURST) || $past(st == ST_BURST))
        else $error("dav outside burst");

    a_grant_with_rq: assert property (@(posedge mclk) disable iff (!rst_n)
        grant |-> rq)
        else $error("grant while rq low");

endmodule

// ==== verilog/hist_readout_mux.sv ====
////////////////////
// histogram readout multiplexer.
// fixed priority pick, burst counting, grant routing, registered data.
////////////////////
`timescale 1ns/100ps

module hist_readout_mux (
    input  logic                             mclk,
    input  logic                             rst_n,
    input  logic                             en,
    input  logic [hist_pkg::NUM_CHN-1:0]     rq_ch,
    input  logic [hist_pkg::NUM_CHN-1:0]     dav_ch,
    input  hist_pkg::hist_word_t             din_0,
    input  hist_pkg::hist_word_t             din_1,
    input  hist_pkg::hist_word_t             din_2,
    input  hist_pkg::hist_word_t             din_3,
    input  logic                             grant,
    output logic [hist_pkg::NUM_CHN-1:0]     grant_ch,
    output logic                             rq,
    output hist_pkg::chn_idx_t               chn,
    output logic                             dv,
    output hist_pkg::hist_word_t             dout
);

    import hist_pkg::*;

    localparam logic [2:0] BURST_LOAD = 3'(8 - BURSTS_PER_CHN);  // counts up to wrap.

    logic [NUM_CHN-1:0][2:0] burst_cnt;   // zero when channel idle.
    hist_word_t              din_arr [NUM_CHN];
    logic                    pri_vld;
    chn_idx_t                pri_idx;
    logic                    enc_vld;     // registered priority encode.
    chn_idx_t                enc_idx;
    logic                    busy_w;
    logic                    busy_r;
    logic                    started;
    logic                    start;
    chn_idx_t                mux_sel;
    logic [NUM_CHN-1:0]      sel_oh;
    logic                    dav_sel;
    hist_word_t              din_sel;
    logic                    rq_sel;
    logic                    burst_done;
    logic                    dv_r;
    hist_word_t              dout_r;
    logic                    rq_r;

    ////////////////////
    // selection

    assign din_arr[0] = din_0;
    assign din_arr[1] = din_1;
    assign din_arr[2] = din_2;
    assign din_arr[3] = din_3;

    always_comb begin
        pri_vld = 1'b0;
        pri_idx = '0;
        for (int i = NUM_CHN - 1; i >= 0; i--) begin
            if (rq_ch[i]) begin
                pri_vld = 1'b1;            // lowest index wins.
                pri_idx = chn_idx_t'(i);
            end
        end
    end

    always_comb begin
        busy_w = 1'b0;
        for (int i = 0; i < NUM_CHN; i++) begin
            busy_w = busy_w | (burst_cnt[i] != 3'd0);
        end
    end

    assign start      = en && enc_vld && !busy_r && !started;
    assign sel_oh     = NUM_CHN'(1) << mux_sel;
    assign dav_sel    = dav_ch[mux_sel];
    assign din_sel    = din_arr[mux_sel];
    assign rq_sel     = rq_ch[mux_sel];
    assign burst_done = dv_r && !dav_sel;  // falling edge of selected dav.

    ////////////////////
    // control

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            enc_vld   <= 1'b0;
            enc_idx   <= '0;
            busy_r    <= 1'b0;
            started   <= 1'b0;
            mux_sel   <= '0;
            burst_cnt <= '0;
            grant_ch  <= '0;
            rq_r      <= 1'b0;
            dv_r      <= 1'b0;
        end else begin
            enc_vld <= pri_vld;
            enc_idx <= pri_idx;
            busy_r  <= busy_w;
            dv_r    <= dav_sel;
            if (!en || busy_r) begin
                started <= 1'b0;
            end else if (enc_vld) begin
                started <= 1'b1;
            end
            if (start) begin
                mux_sel <= enc_idx;
            end
            if (!en) begin
                burst_cnt <= '0;
                grant_ch  <= '0;
                rq_r      <= 1'b0;
            end else begin
                for (int i = 0; i < NUM_CHN; i++) begin
                    if (start && (enc_idx == chn_idx_t'(i))) begin
                        burst_cnt[i] <= BURST_LOAD;
                    end else if (burst_done && sel_oh[i]) begin
                        burst_cnt[i] <= burst_cnt[i] + 3'd1;  // 7 wraps to idle.
                    end
                end
                grant_ch <= {NUM_CHN{grant && rq_r}} & sel_oh;
                if (started) begin
                    rq_r <= 1'b1;
                end else if (rq_r) begin
                    rq_r <= rq_sel;        // follow the channel once up.
                end
            end
        end
    end

    always_ff @(posedge mclk) begin
        dout_r <= din_sel;
    end

    assign rq   = rq_r;
    assign chn  = mux_sel;
    assign dv   = dv_r;
    assign dout = dout_r;

    ////////////////////
    // checks

    a_grant_onehot: assert property (@(posedge mclk) disable iff (!rst_n)
        $onehot0(grant_ch) && ((grant_ch & ~rq_ch) == '0))
        else $error("grant routed to more than one or a non-requesting channel");

    a_dv_when_busy: assert property (@(posedge mclk) disable iff (!rst_n)
        $rose(dv_r) |-> busy_w)
        else $error("dv rose with no burst counter active");

endmodule

// ==== verilog/hist_subsystem.sv ====
////////////////////
// histogram readout subsystem.
// four channels behind one readout multiplexer.
////////////////////
`timescale 1ns/100ps

module hist_subsystem #(
    parameter int PIX_BITS = 8
) (
    input  logic                         mclk,
    input  logic                         rst_n,
    input  logic                         en,
    input  logic [hist_pkg::NUM_CHN-1:0] pix_valid,
    input  logic [PIX_BITS-1:0]          pix_0,
    input  logic [PIX_BITS-1:0]          pix_1,
    input  logic [PIX_BITS-1:0]          pix_2,
    input  logic [PIX_BITS-1:0]          pix_3,
    input  logic [hist_pkg::NUM_CHN-1:0] frame_end,
    input  logic                         grant,
    output logic                         rq,
    output hist_pkg::chn_idx_t           chn,
    output logic                         dv,
    output hist_pkg::hist_word_t         dout
);

    import hist_pkg::*;

    logic [NUM_CHN-1:0] rq_ch;     // channel readout requests.
    logic [NUM_CHN-1:0] dav_ch;
    logic [NUM_CHN-1:0] grant_ch;  // one burst per pulse.
    hist_word_t         chn_dout_0;
    hist_word_t         chn_dout_1;
    hist_word_t         chn_dout_2;
    hist_word_t         chn_dout_3;

    ////////////////////
    // channels

    hist_channel #(.PIX_BITS(PIX_BITS)) i_chn_0 (
        .mclk(mclk), .rst_n(rst_n), .pix_valid(pix_valid[0]), .pix(pix_0),
        .frame_end(frame_end[0]), .grant(grant_ch[0]),
        .rq(rq_ch[0]), .dav(dav_ch[0]), .dout(chn_dout_0)
    );

    hist_channel #(.PIX_BITS(PIX_BITS)) i_chn_1 (
        .mclk(mclk), .rst_n(rst_n), .pix_valid(pix_valid[1]), .pix(pix_1),
        .frame_end(frame_end[1]), .grant(grant_ch[1]),
        .rq(rq_ch[1]), .dav(dav_ch[1]), .dout(chn_dout_1)
    );

    hist_channel #(.PIX_BITS(PIX_BITS)) i_chn_2 (
        .mclk(mclk), .rst_n(rst_n), .pix_valid(pix_valid[2]), .pix(pix_2),
        .frame_end(frame_end[2]), .grant(grant_ch[2]),
        .rq(rq_ch[2]), .dav(dav_ch[2]), .dout(chn_dout_2)
    );

    hist_channel #(.PIX_BITS(PIX_BITS)) i_chn_3 (
        .mclk(mclk), .rst_n(rst_n), .pix_valid(pix_valid[3]), .pix(pix_3),
        .frame_end(frame_end[3]), .grant(grant_ch[3]),
        .rq(rq_ch[3]), .dav(dav_ch[3]), .dout(chn_dout_3)
    );

    ////////////////////
    // readout mux

    hist_readout_mux i_mux (
        .mclk(mclk), .rst_n(rst_n), .en(en),
        .rq_ch(rq_ch), .dav_ch(dav_ch),
        .din_0(chn_dout_0), .din_1(chn_dout_1), .din_2(chn_dout_2), .din_3(chn_dout_3),
        .grant(grant), .grant_ch(grant_ch),
        .rq(rq), .chn(chn), .dv(dv), .dout(dout)
    );

endmodule

// ==== testbench/tb_hist_subsystem.sv ====
////////////////////
// histogram subsystem testbench.
// random frames, count model, grant source, readout checks.
////////////////////
`timescale 1ns/100ps

module tb_hist_subsystem;

    import hist_pkg::*;

    localparam int PIX_BITS  = 6;
    localparam int NUM_BINS  = 1 << PIX_BITS;         // 64 bins per channel.
    localparam int BURST_LEN = NUM_BINS / 4;          // four equal bursts.
    localparam int GRANT_LAT = 3;                     // grant to dv rise, cycles.

    logic                mclk = 1'b0;
    logic                rst_n;
    logic                en;
    logic [3:0]          pix_valid;
    logic [PIX_BITS-1:0] pix_d [4];
    logic [3:0]          frame_end;
    logic                grant_auto = 1'b0;           // from the grant generator.
    logic                grant_man;                   // hand-driven pulse.
    logic                grant;
    logic                rq;
    chn_idx_t            chn;
    logic                dv;
    hist_word_t          dout;

    int unsigned         model [4][NUM_BINS];         // expected bin counts.
    hist_word_t          got_data [$];                // collected readout words.
    logic [1:0]          got_chn [$];
    int                  errors = 0;
    int                  checks = 0;
    int                  tests_run = 0;
    int                  grants = 0;
    bit                  abort = 1'b0;                // a main-flow wait timed out.
    bit                  grant_on;
    int                  gen_st = 0;
    int                  gen_delay = 0;
    int                  gen_cnt = 0;

    assign grant = grant_auto | grant_man;

    always #2 mclk = ~mclk;                           // 4 ns period.

    hist_subsystem #(.PIX_BITS(PIX_BITS)) i_dut (
        .mclk(mclk), .rst_n(rst_n), .en(en), .pix_valid(pix_valid),
        .pix_0(pix_d[0]), .pix_1(pix_d[1]), .pix_2(pix_d[2]), .pix_3(pix_d[3]),
        .frame_end(frame_end), .grant(grant),
        .rq(rq), .chn(chn), .dv(dv), .dout(dout)
    );

    ////////////////////
    // helpers

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic report_and_finish();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0 && !abort) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic send_pixels(input logic [3:0] mask, input int n, input bit runs);
        for (int i = 0; i < n; i++) begin
            @(negedge mclk);
            for (int c = 0; c < 4; c++) begin
                pix_valid[c] = 1'b0;
                if (mask[c]) begin
                    if (!runs || ($urandom % 4) == 0) begin
                        pix_d[c] = PIX_BITS'($urandom);    // new value, else repeat.
                    end
                    pix_valid[c] = runs ? 1'b1 : (($urandom % 4) != 0);
                    if (pix_valid[c]) begin
                        model[c][pix_d[c]]++;
                    end
                end
            end
        end
        @(negedge mclk);
        pix_valid = '0;
    endtask

    task automatic end_frame(input logic [3:0] mask);
        @(negedge mclk);
        frame_end = mask;                             // one-cycle pulse.
        @(negedge mclk);
        frame_end = '0;
    endtask

    task automatic wait_words(input int n);
        int cyc;
        cyc = 0;
        while (got_data.size() < n && !abort) begin
            @(negedge mclk);
            cyc++;
            if (cyc > n * 40 + 400) begin
                $display("timeout waiting for %0d readout words, got %0d", n, got_data.size());
                errors++;
                abort = 1'b1;
            end
        end
    endtask

    // pops the expected words in channel order and clears the model behind them.
    task automatic check_readout(input logic [3:0] mask, input string name);
        int         n;
        hist_word_t word;
        logic [1:0] wchn;
        n = 0;
        for (int c = 0; c < 4; c++) begin
            if (mask[c]) n += NUM_BINS;
        end
        wait_words(n);
        if (abort) return;
        for (int c = 0; c < 4; c++) begin
            if (mask[c]) begin
                for (int b = 0; b < NUM_BINS; b++) begin
                    word = got_data.pop_front();
                    wchn = got_chn.pop_front();
                    check_value($sformatf("%s chn word %0d", name, b), c, 32'(wchn));
                    check_value($sformatf("%s ch%0d bin%0d", name, c, b), model[c][b], word);
                    model[c][b] = 0;                  // bin cleared on read.
                end
            end
        end
        repeat (8) @(negedge mclk);
        check_value({name, " extra words"}, 0, got_data.size());
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
        end
    endtask

    ////////////////////
    // grant source and collector

    always @(negedge mclk) begin
        grant_auto = 1'b0;
        case (gen_st)
            0: if (grant_on && rq && !dv) begin
                gen_delay = $urandom % 6;             // 0 to 5 cycles.
                gen_st    = 1;
            end
            1: if (gen_delay == 0) begin
                grant_auto = 1'b1;
                grants++;
                gen_cnt = 0;
                gen_st  = 2;
            end else begin
                gen_delay--;
            end
            2: begin
                gen_cnt++;
                if (dv) begin
                    check_value("grant latency", GRANT_LAT, gen_cnt);
                    gen_cnt = 1;
                    gen_st  = 3;
                end else if (gen_cnt > 50) begin
                    $display("timeout waiting for dv after a grant");
                    errors++;
                    gen_st = 0;
                end
            end
            default: if (dv) begin
                gen_cnt++;
            end else begin
                check_value("burst length", BURST_LEN, gen_cnt);
                gen_st = 0;                           // next grant only after dv fell.
            end
        endcase
    end

    always @(negedge mclk) begin
        if (rst_n && dv) begin
            got_data.push_back(dout);
            got_chn.push_back(chn);
        end
    end

    initial begin
        #200_000;
        $display("watchdog expired before the tests completed");
        errors++;
        report_and_finish();
    end

    ////////////////////
    // test sequence

    initial begin
        int  err0;
        int  g0;
        bit  rq_seen;
        bit  dv_seen;
        void'($urandom(68818));
        rst_n     = 1'b0;
        en        = 1'b1;
        pix_valid = '0;
        frame_end = '0;
        grant_man = 1'b0;
        grant_on  = 1'b1;
        for (int c = 0; c < 4; c++) begin
            pix_d[c] = '0;
            for (int b = 0; b < NUM_BINS; b++) model[c][b] = 0;
        end
        repeat (10) @(negedge mclk);
        rst_n = 1'b1;
        repeat (NUM_BINS + 4) @(negedge mclk);        // bin clear sweep.

        err0 = errors;                                // single channel.
        send_pixels(4'b0001, 300, 1'b0);
        end_frame(4'b0001);
        check_readout(4'b0001, "single");
        finish_test("single-channel readout", err0);

        if (!abort) begin                             // runs of one bin.
            err0 = errors;
            send_pixels(4'b0010, 400, 1'b1);
            end_frame(4'b0010);
            check_readout(4'b0010, "runs");
            finish_test("repeated bins", err0);
        end

        if (!abort) begin                             // all four at once.
            err0 = errors;
            g0   = grants;
            send_pixels(4'b1111, 250, 1'b0);
            end_frame(4'b1111);
            check_readout(4'b1111, "priority");
            check_value("priority grant count", 16, grants - g0);
            finish_test("priority and bursts", err0);
        end

        if (!abort) begin                             // second frame after clear.
            err0 = errors;
            send_pixels(4'b1111, 200, 1'b1);
            end_frame(4'b1111);
            check_readout(4'b1111, "clear");
            finish_test("clear on read", err0);
        end

        if (!abort) begin
            err0 = errors;
            g0   = grants;
            send_pixels(4'b0100, 300, 1'b0);
            end_frame(4'b0100);
            check_readout(4'b0100, "latency");
            check_value("latency grant count", 4, grants - g0);
            finish_test("grant latency", err0);
        end

        if (!abort) begin                             // enable held low.
            err0     = errors;
            grant_on = 1'b0;
            en       = 1'b0;
            rq_seen  = 1'b0;
            dv_seen  = 1'b0;
            send_pixels(4'b1000, 200, 1'b0);
            end_frame(4'b1000);
            repeat (12) begin
                @(negedge mclk);
                rq_seen |= rq;
            end
            grant_man = 1'b1;                         // must be ignored.
            @(negedge mclk);
            grant_man = 1'b0;
            repeat (12) begin
                @(negedge mclk);
                rq_seen |= rq;
                dv_seen |= dv;
            end
            check_value("enable rq low", 0, 32'(rq_seen));
            check_value("enable dv low", 0, 32'(dv_seen));
            en       = 1'b1;
            grant_on = 1'b1;
            check_readout(4'b1000, "enable");
            finish_test("enable", err0);
        end

        report_and_finish();
    end

endmodule

// ==== flist.f ====
verilog/hist_pkg.sv
verilog/hist_channel.sv
verilog/hist_readout_mux.sv
verilog/hist_subsystem.sv
testbench/tb_hist_subsystem.sv

// ==== Makefile ====
# Verilator lint, simulation and clean for the histogram readout subsystem.

TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
LFLAGS  = --lint-only --timing
TOP     = tb_hist_subsystem
FLIST   = flist.f
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(TOOL) $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides pass or fail, so a crash without the message also fails.
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
